// ==== rtl/segre_params.svh ====
`ifndef SEGRE_PARAMS_SVH
`define SEGRE_PARAMS_SVH

// Datapath and address widths
`define SEGRE_XLEN      32
`define SEGRE_ADDR_SIZE 32

// Index width for 32 registers
`define SEGRE_RF_ADDR   5

// Reset vector
`define SEGRE_BOOT_PC   32'h0000_0000

`endif

// ==== rtl/segre_isa_pkg.sv ====
package segre_isa_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // funct3 codes
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_WORD = 3'b010;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_type_t;

    // Also carries the scrambled J-type immediate
    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
    } instr_u;

endpackage : segre_isa_pkg

// ==== rtl/segre_core_pkg.sv ====
package segre_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    // JUMP is always taken
    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JUMP
    } br_kind_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } memop_e;

    // Source of the register write value
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK
    } wb_src_e;

endpackage : segre_core_pkg

// ==== rtl/segre_stage_if.sv ====
`include "segre_params.svh"

// Decoded instruction from decode to execute
interface segre_dec_ex_if;
    import segre_core_pkg::*;

    logic                        valid;
    logic [`SEGRE_ADDR_SIZE-1:0] pc;
    logic [`SEGRE_XLEN-1:0]      op_a;
    logic [`SEGRE_XLEN-1:0]      op_b;
    alu_op_e                     alu_op;
    br_kind_e                    br_kind;
    logic [`SEGRE_XLEN-1:0]      br_offset;
    logic [`SEGRE_XLEN-1:0]      store_data;
    memop_e                      memop;
    wb_src_e                     wb_src;
    logic                        rf_we;
    logic [`SEGRE_RF_ADDR-1:0]   rf_waddr;

    modport source (output valid, pc, op_a, op_b, alu_op, br_kind, br_offset,
                    output store_data, memop, wb_src, rf_we, rf_waddr);
    modport sink (input valid, pc, op_a, op_b, alu_op, br_kind, br_offset,
                  input store_data, memop, wb_src, rf_we, rf_waddr);
endinterface : segre_dec_ex_if

// Execute results on their way to the result block
interface segre_ex_res_if;
    import segre_core_pkg::*;

    logic                        valid;
    logic [`SEGRE_XLEN-1:0]      alu_result;
    logic                        taken;
    logic [`SEGRE_ADDR_SIZE-1:0] next_pc;
    logic [`SEGRE_ADDR_SIZE-1:0] link;
    logic [`SEGRE_XLEN-1:0]      store_data;
    memop_e                      memop;
    wb_src_e                     wb_src;
    logic                        rf_we;
    logic [`SEGRE_RF_ADDR-1:0]   rf_waddr;

    modport source (output valid, alu_result, taken, next_pc, link, store_data,
                    output memop, wb_src, rf_we, rf_waddr);
    modport sink (input valid, alu_result, taken, next_pc, link, store_data,
                  input memop, wb_src, rf_we, rf_waddr);
endinterface : segre_ex_res_if

// Data access request from result to the shared memory port
interface segre_mem_if;
    logic                        rd_req;
    logic                        wr_req;
    logic [`SEGRE_ADDR_SIZE-1:0] addr;
    logic [`SEGRE_XLEN-1:0]      wdata;
    logic [`SEGRE_XLEN-1:0]      rdata;
    logic                        done;

    modport source (output rd_req, wr_req, addr, wdata, input rdata, done);
    modport sink (input rd_req, wr_req, addr, wdata, output rdata, done);
endinterface : segre_mem_if

// ==== rtl/segre_fetch_mem.sv ====
`include "segre_params.svh"

module segre_fetch_mem (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        retire_i,
    input  logic [`SEGRE_ADDR_SIZE-1:0] next_pc_i,
    output segre_isa_pkg::instr_u       instr_o,
    output logic [`SEGRE_ADDR_SIZE-1:0] pc_o,
    output logic                        instr_valid_o,
    segre_mem_if.sink                   mem,
    input  logic                        mm_data_rdy_i,
    input  logic [`SEGRE_XLEN-1:0]      mm_rd_data_i,
    output logic [`SEGRE_XLEN-1:0]      mm_wr_data_o,
    output logic [`SEGRE_ADDR_SIZE-1:0] mm_addr_o,
    output logic                        mm_rd_o,
    output logic                        mm_wr_o
);

    typedef enum logic [1:0] {
        S_FETCH,
        S_WAIT_RETIRE,
        S_DATA
    } state_e;

    state_e state_q;
    logic   fetch_q;
    logic   data_sel;

    // Fetch and data access never overlap, so the port is a plain mux
    assign data_sel     = (state_q == S_DATA);
    assign mm_rd_o      = fetch_q | (data_sel & mem.rd_req);
    assign mm_wr_o      = data_sel & mem.wr_req;
    assign mm_addr_o    = data_sel ? mem.addr : pc_o;
    assign mm_wr_data_o = mem.wdata;
    assign mem.rdata    = mm_rd_data_i;
    assign mem.done     = data_sel & mm_data_rdy_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= S_FETCH;
            fetch_q       <= 1'b0;
            instr_valid_o <= 1'b0;
            pc_o          <= `SEGRE_BOOT_PC;
        end else begin
            instr_valid_o <= 1'b0;
            case (state_q)
                S_FETCH: begin
                    // Only idle here right after reset
                    if (!fetch_q) begin
                        fetch_q <= 1'b1;
                    end else if (mm_data_rdy_i) begin
                        fetch_q       <= 1'b0;
                        instr_valid_o <= 1'b1;
                        state_q       <= S_WAIT_RETIRE;
                    end
                end
                S_WAIT_RETIRE: begin
                    if (retire_i) begin
                        pc_o    <= next_pc_i;
                        fetch_q <= 1'b1;
                        state_q <= S_FETCH;
                    end else if (mem.rd_req || mem.wr_req) begin
                        state_q <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (mm_data_rdy_i) state_q <= S_WAIT_RETIRE;
                end
                default: state_q <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_q && mm_data_rdy_i) begin
            instr_o <= mm_rd_data_i;
        end
    end

endmodule : segre_fetch_mem

// ==== rtl/segre_decode.sv ====
`include "segre_params.svh"

module segre_decode (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  segre_isa_pkg::instr_u       instr_i,
    input  logic [`SEGRE_ADDR_SIZE-1:0] pc_i,
    input  logic                        instr_valid_i,
    output logic [`SEGRE_RF_ADDR-1:0]   rf_raddr_a_o,
    output logic [`SEGRE_RF_ADDR-1:0]   rf_raddr_b_o,
    input  logic [`SEGRE_XLEN-1:0]      rf_data_a_i,
    input  logic [`SEGRE_XLEN-1:0]      rf_data_b_i,
    segre_dec_ex_if.source              dec_ex
);
    import segre_isa_pkg::*;
    import segre_core_pkg::*;

    logic [`SEGRE_XLEN-1:0] imm_i;
    logic [`SEGRE_XLEN-1:0] imm_s;
    logic [`SEGRE_XLEN-1:0] imm_b;
    logic [`SEGRE_XLEN-1:0] imm_u;
    logic [`SEGRE_XLEN-1:0] imm_j;
    logic [`SEGRE_XLEN-1:0] op_b;
    logic [`SEGRE_XLEN-1:0] offset;
    alu_op_e                alu_op;
    br_kind_e               br_kind;
    memop_e                 memop;
    wb_src_e                wb_src;
    logic                   rf_we;

    assign rf_raddr_a_o = instr_i.r.rs1;
    assign rf_raddr_b_o = instr_i.r.rs2;

    // Sign-extended immediates from the overlapping views
    assign imm_i = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
    assign imm_s = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5, instr_i.s.imm_4_0};
    assign imm_b = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                    instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
    assign imm_u = {instr_i.u.imm_31_12, 12'b0};
    assign imm_j = {{11{instr_i.u.imm_31_12[19]}}, instr_i.u.imm_31_12[19],
                    instr_i.u.imm_31_12[7:0], instr_i.u.imm_31_12[8],
                    instr_i.u.imm_31_12[18:9], 1'b0};

    always_comb begin
        op_b    = imm_i;
        offset  = imm_b;
        alu_op  = ALU_ADD;
        br_kind = BR_NONE;
        memop   = MEM_NONE;
        wb_src  = WB_ALU;
        rf_we   = 1'b0;
        case (instr_i.r.opcode)
            OPC_OP: begin
                op_b  = rf_data_b_i;
                rf_we = (instr_i.r.funct7 == F7_BASE) ||
                        (instr_i.r.funct7 == F7_ALT && instr_i.r.funct3 == F3_ADD);
                case (instr_i.r.funct3)
                    F3_ADD:  alu_op = (instr_i.r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_SRL:  alu_op = ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: rf_we = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                rf_we = 1'b1;
                case (instr_i.i.funct3)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    // Immediate shifts and SLTIU are not supported
                    default: rf_we = 1'b0;
                endcase
            end
            OPC_LUI: begin
                op_b   = imm_u;
                alu_op = ALU_PASS_B;
                rf_we  = 1'b1;
            end
            OPC_LOAD: begin
                if (instr_i.i.funct3 == F3_WORD) begin
                    memop  = MEM_LOAD;
                    wb_src = WB_MEM;
                    rf_we  = 1'b1;
                end
            end
            OPC_STORE: begin
                op_b = imm_s;
                if (instr_i.s.funct3 == F3_WORD) memop = MEM_STORE;
            end
            OPC_BRANCH: begin
                op_b = rf_data_b_i;
                if (instr_i.b.funct3 == F3_BEQ) br_kind = BR_EQ;
                if (instr_i.b.funct3 == F3_BNE) br_kind = BR_NE;
            end
            OPC_JAL: begin
                offset  = imm_j;
                br_kind = BR_JUMP;
                wb_src  = WB_LINK;
                rf_we   = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) dec_ex.valid <= 1'b0;
        else dec_ex.valid <= instr_valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            dec_ex.pc         <= pc_i;
            dec_ex.op_a       <= rf_data_a_i;
            dec_ex.op_b       <= op_b;
            dec_ex.alu_op     <= alu_op;
            dec_ex.br_kind    <= br_kind;
            dec_ex.br_offset  <= offset;
            dec_ex.store_data <= rf_data_b_i;
            dec_ex.memop      <= memop;
            dec_ex.wb_src     <= wb_src;
            dec_ex.rf_we      <= rf_we;
            dec_ex.rf_waddr   <= instr_i.r.rd;
        end
    end

endmodule : segre_decode

// ==== rtl/segre_register_file.sv ====
`include "segre_params.svh"

module segre_register_file (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [`SEGRE_RF_ADDR-1:0] raddr_a_i,
    input  logic [`SEGRE_RF_ADDR-1:0] raddr_b_i,
    output logic [`SEGRE_XLEN-1:0]    data_a_o,
    output logic [`SEGRE_XLEN-1:0]    data_b_o,
    input  logic                      we_i,
    input  logic [`SEGRE_RF_ADDR-1:0] waddr_i,
    input  logic [`SEGRE_XLEN-1:0]    wdata_i
);

    logic [`SEGRE_XLEN-1:0] regs_q [2**`SEGRE_RF_ADDR];

    assign data_a_o = regs_q[raddr_a_i];
    assign data_b_o = regs_q[raddr_b_i];

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**`SEGRE_RF_ADDR; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

endmodule : segre_register_file

// ==== rtl/segre_execute.sv ====
`include "segre_params.svh"

module segre_execute (
    input  logic           clk_i,
    input  logic           rst_n_i,
    segre_dec_ex_if.sink   dec_ex,
    segre_ex_res_if.source ex_res
);
    import segre_core_pkg::*;

    logic [`SEGRE_XLEN-1:0]      alu_res;
    logic                        taken;
    logic [`SEGRE_ADDR_SIZE-1:0] pc_plus4;
    logic [`SEGRE_ADDR_SIZE-1:0] target;

    always_comb begin
        case (dec_ex.alu_op)
            ALU_SUB:    alu_res = dec_ex.op_a - dec_ex.op_b;
            ALU_AND:    alu_res = dec_ex.op_a & dec_ex.op_b;
            ALU_OR:     alu_res = dec_ex.op_a | dec_ex.op_b;
            ALU_XOR:    alu_res = dec_ex.op_a ^ dec_ex.op_b;
            ALU_SLT:    alu_res = {{(`SEGRE_XLEN-1){1'b0}},
                                   $signed(dec_ex.op_a) < $signed(dec_ex.op_b)};
            ALU_SLL:    alu_res = dec_ex.op_a << dec_ex.op_b[4:0];
            ALU_SRL:    alu_res = dec_ex.op_a >> dec_ex.op_b[4:0];
            ALU_PASS_B: alu_res = dec_ex.op_b;
            default:    alu_res = dec_ex.op_a + dec_ex.op_b;
        endcase
    end

    // Branches compare the two register operands
    always_comb begin
        case (dec_ex.br_kind)
            BR_EQ:   taken = (dec_ex.op_a == dec_ex.op_b);
            BR_NE:   taken = (dec_ex.op_a != dec_ex.op_b);
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = dec_ex.pc + 4;
    assign target   = dec_ex.pc + dec_ex.br_offset;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) ex_res.valid <= 1'b0;
        else ex_res.valid <= dec_ex.valid;
    end

    always_ff @(posedge clk_i) begin
        if (dec_ex.valid) begin
            ex_res.alu_result <= alu_res;
            ex_res.taken      <= taken;
            ex_res.next_pc    <= taken ? target : pc_plus4;
            ex_res.link       <= pc_plus4;
            ex_res.store_data <= dec_ex.store_data;
            ex_res.memop      <= dec_ex.memop;
            ex_res.wb_src     <= dec_ex.wb_src;
            ex_res.rf_we      <= dec_ex.rf_we;
            ex_res.rf_waddr   <= dec_ex.rf_waddr;
        end
    end

endmodule : segre_execute

// ==== rtl/segre_result.sv ====
`include "segre_params.svh"

module segre_result (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    segre_ex_res_if.sink                ex_res,
    segre_mem_if.source                 mem,
    output logic                        rf_we_o,
    output logic [`SEGRE_RF_ADDR-1:0]   rf_waddr_o,
    output logic [`SEGRE_XLEN-1:0]      rf_wdata_o,
    output logic                        retire_o,
    output logic [`SEGRE_ADDR_SIZE-1:0] next_pc_o
);
    import segre_core_pkg::*;

    logic                   finish;
    logic [`SEGRE_XLEN-1:0] wb_data;

    // Retire right away, or once the memory access is done
    assign finish = (ex_res.valid && ex_res.memop == MEM_NONE) || mem.done;

    // Execute holds its outputs while the access is pending
    assign mem.addr  = ex_res.alu_result;
    assign mem.wdata = ex_res.store_data;

    always_comb begin
        case (ex_res.wb_src)
            WB_MEM:  wb_data = mem.rdata;
            WB_LINK: wb_data = ex_res.link;
            default: wb_data = ex_res.alu_result;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem.rd_req <= 1'b0;
            mem.wr_req <= 1'b0;
            rf_we_o    <= 1'b0;
            retire_o   <= 1'b0;
        end else begin
            if (mem.done) begin
                mem.rd_req <= 1'b0;
                mem.wr_req <= 1'b0;
            end else if (ex_res.valid) begin
                mem.rd_req <= (ex_res.memop == MEM_LOAD);
                mem.wr_req <= (ex_res.memop == MEM_STORE);
            end
            retire_o <= finish;
            rf_we_o  <= finish && ex_res.rf_we;
        end
    end

    always_ff @(posedge clk_i) begin
        if (finish) begin
            rf_waddr_o <= ex_res.rf_waddr;
            rf_wdata_o <= wb_data;
            // Not taken means fall through to the link address
            next_pc_o  <= ex_res.taken ? ex_res.next_pc : ex_res.link;
        end
    end

endmodule : segre_result

// ==== rtl/segre_core.sv ====
`include "segre_params.svh"

module segre_core (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        mm_data_rdy_i,
    input  logic [`SEGRE_XLEN-1:0]      mm_rd_data_i,
    output logic [`SEGRE_XLEN-1:0]      mm_wr_data_o,
    output logic [`SEGRE_ADDR_SIZE-1:0] mm_addr_o,
    output logic                        mm_rd_o,
    output logic                        mm_wr_o
);
    import segre_isa_pkg::*;

    // Fetch to decode
    instr_u                      instr;
    logic [`SEGRE_ADDR_SIZE-1:0] instr_pc;
    logic                        instr_valid;

    // Register file ports
    logic [`SEGRE_RF_ADDR-1:0]   rf_raddr_a;
    logic [`SEGRE_RF_ADDR-1:0]   rf_raddr_b;
    logic [`SEGRE_XLEN-1:0]      rf_data_a;
    logic [`SEGRE_XLEN-1:0]      rf_data_b;
    logic                        rf_we;
    logic [`SEGRE_RF_ADDR-1:0]   rf_waddr;
    logic [`SEGRE_XLEN-1:0]      rf_wdata;

    // Retire back to fetch
    logic                        retire;
    logic [`SEGRE_ADDR_SIZE-1:0] next_pc;

    segre_dec_ex_if dec_ex ();
    segre_ex_res_if ex_res ();
    segre_mem_if    mem_bus ();

    segre_fetch_mem fetch_mem (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .retire_i      (retire),
        .next_pc_i     (next_pc),
        .instr_o       (instr),
        .pc_o          (instr_pc),
        .instr_valid_o (instr_valid),
        .mem           (mem_bus.sink),
        .mm_data_rdy_i (mm_data_rdy_i),
        .mm_rd_data_i  (mm_rd_data_i),
        .mm_wr_data_o  (mm_wr_data_o),
        .mm_addr_o     (mm_addr_o),
        .mm_rd_o       (mm_rd_o),
        .mm_wr_o       (mm_wr_o)
    );

    segre_decode decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr),
        .pc_i          (instr_pc),
        .instr_valid_i (instr_valid),
        .rf_raddr_a_o  (rf_raddr_a),
        .rf_raddr_b_o  (rf_raddr_b),
        .rf_data_a_i   (rf_data_a),
        .rf_data_b_i   (rf_data_b),
        .dec_ex        (dec_ex.source)
    );

    segre_register_file register_file (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .data_a_o  (rf_data_a),
        .data_b_o  (rf_data_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    segre_execute execute (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .dec_ex  (dec_ex.sink),
        .ex_res  (ex_res.source)
    );

    segre_result result (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ex_res     (ex_res.sink),
        .mem        (mem_bus.source),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .retire_o   (retire),
        .next_pc_o  (next_pc)
    );

endmodule : segre_core

// ==== testbench/tb_segre_memory.sv ====
module tb_segre_memory (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        mm_rd_i,
    input  logic        mm_wr_i,
    input  logic [31:0] mm_addr_i,
    input  logic [31:0] mm_wr_data_i,
    output logic        mm_data_rdy_o,
    output logic [31:0] mm_rd_data_o,
    output logic [31:0] last_wr_addr_o,
    output logic [31:0] last_wr_data_o,
    output logic [31:0] wr_count_o
);

    // 256 words covering byte addresses 0x000 to 0x3ff
    logic [31:0] mem [256];
    logic [31:0] seed;
    logic        busy;
    int          wait_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        mm_data_rdy_o  = 1'b0;
        mm_rd_data_o   = '0;
        last_wr_addr_o = '0;
        last_wr_data_o = '0;
        wr_count_o     = '0;
        seed           = 32'ha7df;
        busy           = 1'b0;
        wait_cnt       = 0;
    end

    always @(posedge clk_i) begin
        #1;
        if (!rst_n_i) begin
            busy          = 1'b0;
            mm_data_rdy_o = 1'b0;
        end else if (mm_data_rdy_o) begin
            // The requester drops its level after this pulse
            mm_data_rdy_o = 1'b0;
        end else if (busy) begin
            if (wait_cnt > 1) begin
                wait_cnt = wait_cnt - 1;
            end else begin
                busy          = 1'b0;
                mm_data_rdy_o = 1'b1;
                if (mm_wr_i) begin
                    mem[mm_addr_i[9:2]] = mm_wr_data_i;
                    last_wr_addr_o      = mm_addr_i;
                    last_wr_data_o      = mm_wr_data_i;
                    wr_count_o          = wr_count_o + 32'd1;
                end else begin
                    mm_rd_data_o = mem[mm_addr_i[9:2]];
                end
            end
        end else if (mm_rd_i || mm_wr_i) begin
            seed     = lcg_next(seed);
            busy     = 1'b1;
            wait_cnt = 1 + int'(seed[17:16]);
        end
    end

endmodule : tb_segre_memory

// ==== testbench/tb_segre_core.sv ====
module tb_segre_core;

    localparam int NUM_TESTS = 8;
    localparam int TIMEOUT   = NUM_TESTS * 60 * 13 * 100;
    localparam logic [31:0] NOP       = 32'h0000_0013;
    localparam logic [31:0] BOOT_ADDR = 32'h0000_0000;

    logic        clk_i;
    logic        rst_n_i;
    logic        mm_data_rdy_i;
    logic [31:0] mm_rd_data_i;
    logic [31:0] mm_wr_data_o;
    logic [31:0] mm_addr_o;
    logic        mm_rd_o;
    logic        mm_wr_o;
    logic [31:0] last_wr_addr;
    logic [31:0] last_wr_data;
    logic [31:0] wr_count;

    string       names [NUM_TESTS];
    logic [31:0] progs [NUM_TESTS][8];
    logic [31:0] exp_addr [NUM_TESTS];
    logic [31:0] exp_val [NUM_TESTS];

    segre_core i_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .mm_data_rdy_i (mm_data_rdy_i),
        .mm_rd_data_i  (mm_rd_data_i),
        .mm_wr_data_o  (mm_wr_data_o),
        .mm_addr_o     (mm_addr_o),
        .mm_rd_o       (mm_rd_o),
        .mm_wr_o       (mm_wr_o)
    );

    tb_segre_memory i_mem (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .mm_rd_i        (mm_rd_o),
        .mm_wr_i        (mm_wr_o),
        .mm_addr_i      (mm_addr_o),
        .mm_wr_data_i   (mm_wr_data_o),
        .mm_data_rdy_o  (mm_data_rdy_i),
        .mm_rd_data_o   (mm_rd_data_i),
        .last_wr_addr_o (last_wr_addr),
        .last_wr_data_o (last_wr_data),
        .wr_count_o     (wr_count)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // RV32I instruction formats
    function automatic logic [31:0] r_format(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_format(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_format(int rs2, int imm, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_format(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_format(int rd, int imm20);
        return {imm20[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] j_format(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic build_table();
        // Each program ends by storing its result to 0x100, then spins
        names[0] = "alu_shift";
        progs[0] = '{i_format(12, 0, 0, 1, 7'h13), i_format(5, 0, 0, 2, 7'h13),
                     r_format(32, 0, 3, 1, 2), r_format(0, 1, 4, 3, 2),
                     r_format(0, 4, 5, 4, 1), r_format(0, 5, 6, 5, 2),
                     s_format(6, 256, 0), j_format(0, 0)};
        exp_val[0] = 32'd7;
        names[1] = "alu_compare";
        progs[1] = '{i_format(-3, 0, 0, 1, 7'h13), i_format(1, 1, 2, 2, 7'h13),
                     r_format(0, 2, 3, 2, 1), r_format(0, 2, 4, 1, 2),
                     r_format(32, 0, 5, 3, 4), r_format(0, 0, 6, 5, 1),
                     s_format(6, 256, 0), j_format(0, 0)};
        exp_val[1] = 32'hffff_fffc;
        names[2] = "alu_logic";
        progs[2] = '{i_format(32'h5f0, 0, 0, 1, 7'h13), i_format(32'h0ff, 1, 7, 2, 7'h13),
                     i_format(32'h00f, 2, 6, 3, 7'h13), i_format(32'h123, 3, 4, 4, 7'h13),
                     r_format(0, 7, 5, 4, 1), r_format(0, 6, 6, 5, 2),
                     s_format(6, 256, 0), j_format(0, 0)};
        exp_val[2] = 32'h0000_01f0;
        names[3] = "lui_constant";
        progs[3] = '{u_format(1, 32'hdeadc), i_format(-273, 1, 0, 1, 7'h13),
                     s_format(1, 256, 0), j_format(0, 0), NOP, NOP, NOP, NOP};
        exp_val[3] = 32'hdead_beef;
        names[4] = "load_store";
        progs[4] = '{i_format(32'h55, 0, 0, 1, 7'h13), s_format(1, 32'h80, 0),
                     i_format(32'h80, 0, 2, 2, 7'h03), i_format(1, 2, 0, 3, 7'h13),
                     s_format(3, 256, 0), j_format(0, 0), NOP, NOP};
        exp_val[4] = 32'h56;
        names[5] = "branch_paths";
        progs[5] = '{i_format(0, 0, 0, 1, 7'h13), i_format(3, 0, 0, 2, 7'h13),
                     b_format(0, 2, 2, 8), i_format(1, 1, 0, 1, 7'h13),
                     b_format(1, 2, 2, 8), i_format(4, 1, 0, 1, 7'h13),
                     s_format(1, 256, 0), j_format(0, 0)};
        exp_val[5] = 32'd4;
        names[6] = "jal_link";
        progs[6] = '{j_format(5, 8), i_format(32'h7f, 0, 0, 5, 7'h13),
                     s_format(5, 256, 0), j_format(0, 0), NOP, NOP, NOP, NOP};
        exp_val[6] = 32'd4;
        names[7] = "x0_fixed";
        progs[7] = '{i_format(9, 0, 0, 0, 7'h13), s_format(0, 256, 0),
                     j_format(0, 0), NOP, NOP, NOP, NOP, NOP};
        exp_val[7] = 32'd0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            exp_addr[t] = 32'h100;
        end
    endtask

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic run_test(int t);
        logic [31:0] start_count;
        @(posedge clk_i);
        #1 rst_n_i = 1'b0;
        repeat (4) begin
            @(negedge clk_i);
            assert (mm_wr_o === 1'b0)
                else stop_on_error($sformatf("%s: memory write raised during reset", names[t]));
        end
        for (int k = 0; k < 256; k++) begin
            i_mem.mem[k] = 32'hbad0_0000 ^ (k << 2);
        end
        for (int k = 0; k < 8; k++) begin
            i_mem.mem[k] = progs[t][k];
        end
        @(posedge clk_i);
        #1 rst_n_i = 1'b1;
        start_count = wr_count;
        @(negedge clk_i);
        assert (mm_wr_o === 1'b0)
            else stop_on_error($sformatf("%s: memory write raised after reset", names[t]));
        while (mm_rd_o !== 1'b1) @(negedge clk_i);
        assert (mm_addr_o == BOOT_ADDR)
            else stop_on_error($sformatf("CHECK FAILED %s boot fetch: expected %h actual %h",
                                         names[t], BOOT_ADDR, mm_addr_o));
        while (!(wr_count != start_count && last_wr_addr == exp_addr[t])) @(negedge clk_i);
        assert (last_wr_data == exp_val[t])
            else stop_on_error($sformatf("CHECK FAILED %s: expected %h actual %h",
                                         names[t], exp_val[t], last_wr_data));
    endtask

    initial begin
        #(TIMEOUT);
        stop_on_error("Timeout: the core never stored its result");
    end

    initial begin
        rst_n_i = 1'b0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Regression passed");
        $finish;
    end

endmodule : tb_segre_core

// ==== src.f ====
+incdir+rtl
rtl/segre_isa_pkg.sv
rtl/segre_core_pkg.sv
rtl/segre_stage_if.sv
rtl/segre_fetch_mem.sv
rtl/segre_decode.sv
rtl/segre_register_file.sv
rtl/segre_execute.sv
rtl/segre_result.sv
rtl/segre_core.sv
testbench/tb_segre_memory.sv
testbench/tb_segre_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core regression with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing -f src.f --top-module tb_segre_core -o sim_core \
    && ./obj_dir/sim_core \
    || exit 1
